//--- sonar_pkg.sv
package sonar_pkg;

    // Bus and sample widths
    typedef logic [31:0]        word_t;
    typedef logic signed [15:0] sample_t;

    // Address map in 32-bit words
    localparam logic [3:0]  ADDR_REGION    = 4'd3;   // Required value of adr[31:28]
    localparam int unsigned STATUS_WORD    = 0;
    localparam int unsigned PRESCALER_WORD = 1;
    localparam int unsigned CHAN_BASE_WORD = 2;
    localparam int unsigned CHAN_STRIDE    = 16;
    localparam int unsigned CHAN_IDX_W     = 6;
    localparam int unsigned MAX_CHANNELS   = 36;

    localparam word_t PRESCALER_RESET = 32'd49;

    typedef enum logic [1:0] {
        TGT_STATUS,
        TGT_PRESCALER,
        TGT_CHANNEL,
        TGT_NONE
    } target_e;

    // Register index inside one channel window
    typedef enum logic [1:0] {
        CREG_THRESHOLD,
        CREG_SAMPLE,
        CREG_OTHER
    } chan_reg_e;

    typedef enum logic {
        DEC_IDLE,
        DEC_WAIT_RELEASE
    } decode_state_e;

    // One decoded bus access, valid for a single cycle
    typedef struct packed {
        logic      valid;
        logic      we;
        target_e   target;
        chan_reg_e chan_reg;
        word_t     wdata;
    } bus_req_t;

endpackage

//--- sonar_bus_decode.sv
`timescale 1ns/10ps

module sonar_bus_decode #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                     wb_clk_i,
    input  logic                     wb_rst_i,
    input  logic                     wbs_cyc_i,
    input  logic                     wbs_stb_i,
    input  logic                     wbs_we_i,
    input  sonar_pkg::word_t         wbs_adr_i,
    input  sonar_pkg::word_t         wbs_dat_i,
    output sonar_pkg::bus_req_t      req_o,
    output logic [NUM_CHANNELS-1:0]  chan_sel_o
);
    import sonar_pkg::*;

    localparam int REG_W = $clog2(CHAN_STRIDE);
    localparam int OFF_W = CHAN_IDX_W + REG_W;

    decode_state_e           state_q;
    logic [OFF_W-1:0]        word_off;
    logic [OFF_W-1:0]        chan_off;
    logic [CHAN_IDX_W-1:0]   chan_idx;
    logic                    hit;
    target_e                 target_d;
    chan_reg_e               creg_d;
    logic [NUM_CHANNELS-1:0] chan_sel_d;

    assign hit      = wbs_cyc_i && wbs_stb_i && (wbs_adr_i[31:28] == ADDR_REGION);
    assign word_off = wbs_adr_i[OFF_W+1:2];
    assign chan_off = word_off - OFF_W'(CHAN_BASE_WORD);
    assign chan_idx = chan_off[OFF_W-1:REG_W];

    always_comb begin
        target_d = TGT_NONE;
        creg_d   = CREG_OTHER;
        if (wbs_adr_i[27:OFF_W+2] != '0) begin
            target_d = TGT_NONE;                 // Beyond the decoded window
        end else if (word_off == OFF_W'(STATUS_WORD)) begin
            target_d = TGT_STATUS;
        end else if (word_off == OFF_W'(PRESCALER_WORD)) begin
            target_d = TGT_PRESCALER;
        end else if (int'(chan_idx) < NUM_CHANNELS) begin
            target_d = TGT_CHANNEL;
        end
        case (chan_off[REG_W-1:0])
            REG_W'(0): creg_d = CREG_THRESHOLD;
            REG_W'(1): creg_d = CREG_SAMPLE;
            default:   creg_d = CREG_OTHER;
        endcase
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chan_sel_d[i] = (target_d == TGT_CHANNEL) && (int'(chan_idx) == i);
        end
    end

    // A held strobe produces exactly one request
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q    <= DEC_IDLE;
            req_o      <= '0;
            chan_sel_o <= '0;
        end else begin
            req_o.valid <= 1'b0;
            chan_sel_o  <= '0;
            case (state_q)
                DEC_IDLE: begin
                    if (hit) begin
                        req_o      <= '{valid: 1'b1, we: wbs_we_i, target: target_d,
                                        chan_reg: creg_d, wdata: wbs_dat_i};
                        chan_sel_o <= chan_sel_d;
                        state_q    <= DEC_WAIT_RELEASE;
                    end
                end
                default: begin
                    if (!wbs_stb_i) state_q <= DEC_IDLE;   // Master released the cycle
                end
            endcase
        end
    end

endmodule

//--- sonar_clock_gen.sv
`timescale 1ns/10ps

module sonar_clock_gen #(
    parameter int MCLK_DIV = 8
) (
    input  logic                wb_clk_i,
    input  logic                wb_rst_i,
    input  sonar_pkg::bus_req_t req_i,
    output sonar_pkg::word_t    prescaler_o,
    output logic                mclk_o,
    output logic                ce_pdm_o,
    output logic                ce_pcm_o
);
    import sonar_pkg::*;

    localparam int HALF  = MCLK_DIV / 2;
    localparam int CNT_W = $clog2(MCLK_DIV);

    logic [CNT_W-1:0] div_cnt;
    word_t            pcm_cnt;

    // Prescaler register
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            prescaler_o <= PRESCALER_RESET;
        end else if (req_i.valid && req_i.we && req_i.target == TGT_PRESCALER) begin
            prescaler_o <= req_i.wdata;
        end
    end

    // Microphone clock, toggles every HALF cycles
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            div_cnt  <= '0;
            mclk_o   <= 1'b0;
            ce_pdm_o <= 1'b0;
        end else begin
            ce_pdm_o <= 1'b0;
            if (div_cnt == CNT_W'(HALF - 1)) begin
                div_cnt  <= '0;
                mclk_o   <= ~mclk_o;
                ce_pdm_o <= ~mclk_o;               // Pulse on the rising toggle only
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // PCM enable every prescaler+1 cycles
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            pcm_cnt  <= PRESCALER_RESET;
            ce_pcm_o <= 1'b0;
        end else if (pcm_cnt == '0) begin
            pcm_cnt  <= prescaler_o;                // New prescaler takes effect here
            ce_pcm_o <= 1'b1;
        end else begin
            pcm_cnt  <= pcm_cnt - 1'b1;
            ce_pcm_o <= 1'b0;
        end
    end

endmodule

//--- sonar_channel.sv
`timescale 1ns/10ps

module sonar_channel (
    input  logic                wb_clk_i,
    input  logic                wb_rst_i,
    input  sonar_pkg::bus_req_t req_i,
    input  logic                sel_i,
    input  logic                ce_pdm_i,
    input  logic                ce_pcm_i,
    input  logic                pdm_i,
    input  logic                mclear_i,
    output sonar_pkg::sample_t  rdata_o,
    output logic                cmp_o
);
    import sonar_pkg::*;

    sample_t     integ_q;
    sample_t     integ_next;
    sample_t     sample_q;
    sample_t     threshold_q;
    logic [16:0] integ_sum;
    logic        pcm_d;
    logic        thr_we;

    assign thr_we = req_i.valid && req_i.we && sel_i && (req_i.chan_reg == CREG_THRESHOLD);

    // Integrate one PDM bit, saturating at the sample limits
    always_comb begin
        integ_sum = {integ_q[15], integ_q} + (pdm_i ? 17'd1 : 17'h1ffff);
        if (!ce_pdm_i) begin
            integ_next = integ_q;
        end else if (integ_sum[16] != integ_sum[15]) begin
            integ_next = integ_sum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            integ_next = integ_sum[15:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            integ_q  <= '0;
            sample_q <= '0;
        end else if (ce_pcm_i) begin
            sample_q <= integ_next;     // Latch and restart
            integ_q  <= '0;
        end else begin
            integ_q  <= integ_next;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            threshold_q <= '0;
        end else if (thr_we) begin
            threshold_q <= {req_i.wdata[31], req_i.wdata[14:0]};
        end
    end

    // Compare one cycle after each new sample
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            pcm_d <= 1'b0;
            cmp_o <= 1'b0;
        end else begin
            pcm_d <= ce_pcm_i;
            if (mclear_i) begin
                cmp_o <= 1'b0;
            end else if (pcm_d) begin
                cmp_o <= sample_q > threshold_q;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        if (sel_i) begin
            case (req_i.chan_reg)
                CREG_THRESHOLD: rdata_o = threshold_q;
                CREG_SAMPLE:    rdata_o = sample_q;
                default:        rdata_o = '0;
            endcase
        end
    end

endmodule

//--- sonar_readback.sv
`timescale 1ns/10ps

module sonar_readback #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                  wb_clk_i,
    input  logic                                  wb_rst_i,
    input  sonar_pkg::bus_req_t                   req_i,
    input  sonar_pkg::sample_t [NUM_CHANNELS-1:0] chan_rdata_i,
    input  logic [NUM_CHANNELS-1:0]               cmp_i,
    input  sonar_pkg::word_t                      prescaler_i,
    output logic                                  wbs_ack_o,
    output sonar_pkg::word_t                      wbs_dat_o,
    output logic                                  irq_o
);
    import sonar_pkg::*;

    logic [NUM_CHANNELS-1:0] status_q;
    sample_t                 chan_or;
    word_t                   rd_word;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            status_q <= '0;
        end else begin
            status_q <= cmp_i;
        end
    end

    assign irq_o = |status_q;

    // Unselected channels drive zero
    always_comb begin
        chan_or = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chan_or = chan_or | chan_rdata_i[i];
        end
    end

    always_comb begin
        case (req_i.target)
            TGT_STATUS:    rd_word = word_t'(status_q);
            TGT_PRESCALER: rd_word = prescaler_i;
            TGT_CHANNEL:   rd_word = {{16{chan_or[15]}}, chan_or};
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o <= 1'b0;
        end else begin
            wbs_ack_o <= req_i.valid;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req_i.valid) wbs_dat_o <= rd_word;
    end

endmodule

//--- sonar_top.sv
`timescale 1ns/10ps

module sonar_top #(
    parameter int NUM_CHANNELS = 4,
    parameter int MCLK_DIV     = 8
) (
    input  logic                    wb_clk_i,
    input  logic                    wb_rst_i,
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_stb_i,
    input  logic                    wbs_we_i,
    input  sonar_pkg::word_t        wbs_adr_i,
    input  sonar_pkg::word_t        wbs_dat_i,
    output logic                    wbs_ack_o,
    output sonar_pkg::word_t        wbs_dat_o,
    input  logic [NUM_CHANNELS-1:0] pdm_i,
    input  logic                    mclear_i,
    output logic                    mclk_o,
    output logic                    irq_o
);
    import sonar_pkg::*;

    bus_req_t                     req;
    logic [NUM_CHANNELS-1:0]      chan_sel;
    word_t                        prescaler;
    logic                         ce_pdm;
    logic                         ce_pcm;
    sample_t [NUM_CHANNELS-1:0]   chan_rdata;
    logic [NUM_CHANNELS-1:0]      cmp;

    sonar_bus_decode #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) decode_inst (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_we_i   (wbs_we_i),
        .wbs_adr_i  (wbs_adr_i),
        .wbs_dat_i  (wbs_dat_i),
        .req_o      (req),
        .chan_sel_o (chan_sel)
    );

    sonar_clock_gen #(
        .MCLK_DIV (MCLK_DIV)
    ) clock_gen_inst (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .req_i       (req),
        .prescaler_o (prescaler),
        .mclk_o      (mclk_o),
        .ce_pdm_o    (ce_pdm),
        .ce_pcm_o    (ce_pcm)
    );

    for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_chan
        sonar_channel chan_inst (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .req_i    (req),
            .sel_i    (chan_sel[k]),
            .ce_pdm_i (ce_pdm),
            .ce_pcm_i (ce_pcm),
            .pdm_i    (pdm_i[k]),
            .mclear_i (mclear_i),
            .rdata_o  (chan_rdata[k]),
            .cmp_o    (cmp[k])
        );
    end

    sonar_readback #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) readback_inst (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .req_i        (req),
        .chan_rdata_i (chan_rdata),
        .cmp_i        (cmp),
        .prescaler_i  (prescaler),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .irq_o        (irq_o)
    );

endmodule

//--- sonar_props.sv
`timescale 1ns/10ps

module sonar_props #(
    parameter int NUM_CHANNELS = 4
) (
    input logic                    wb_clk_i,
    input logic                    wb_rst_i,
    input logic                    wbs_ack_i,
    input logic                    ce_pcm_i,
    input logic                    irq_i,
    input logic [NUM_CHANNELS-1:0] cmp_i
);

    ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_i |=> !wbs_ack_i)
        else $error("wbs_ack_o stayed high for two cycles");

    ce_pcm_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ce_pcm_i |=> !ce_pcm_i)
        else $error("ce_pcm pulse wider than one cycle");

    // Status holds the channel flags one cycle late and irq is their OR
    irq_is_status_or: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        irq_i == $past(|cmp_i))
        else $error("irq_o differs from the OR of the status bits");

endmodule

bind sonar_top sonar_props #(
    .NUM_CHANNELS (NUM_CHANNELS)
) props_inst (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_ack_i (wbs_ack_o),
    .ce_pcm_i  (ce_pcm),
    .irq_i     (irq_o),
    .cmp_i     (cmp)
);

//--- tb_sonar_top.sv
`timescale 1ns/10ps

module tb_sonar_top;
    import sonar_pkg::*;

    localparam int    NUM_CH            = 4;
    localparam int    MCLK_HALF         = 4;       // MCLK_DIV of 8 toggles every 4 cycles
    localparam int    ACK_WAIT_MAX      = 8;
    localparam int    MCLK_CHECK_CYCLES = 40;
    localparam word_t LFSR_SEED         = 32'h2136_968c;
    localparam word_t LFSR_TAPS         = 32'hb4bc_d35c;

    typedef struct packed {
        logic              is_write;
        logic [15:0]       offset;
        word_t             wdata;
        word_t             expected;
        logic              chk_data;
        logic              chk_irq;
        logic              exp_irq;
        logic [15:0]       settle;       // Idle cycles before the access
        logic [NUM_CH-1:0] pdm;
        logic              mclear;
    } entry_t;

    logic              wb_clk_i;
    logic              wb_rst_i;
    logic              wbs_cyc_i;
    logic              wbs_stb_i;
    logic              wbs_we_i;
    word_t             wbs_adr_i;
    word_t             wbs_dat_i;
    logic              wbs_ack_o;
    word_t             wbs_dat_o;
    logic [NUM_CH-1:0] pdm_i;
    logic              mclear_i;
    logic              mclk_o;
    logic              irq_o;

    entry_t            stim_q[$];
    word_t             lfsr_state;
    logic [NUM_CH-1:0] next_pdm;
    logic              next_mclear;
    int                cycle_count = 0;
    int                cycle_limit = 0;

    sonar_top #(
        .NUM_CHANNELS (NUM_CH),
        .MCLK_DIV     (8)
    ) sonar_top_inst (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .pdm_i     (pdm_i),
        .mclear_i  (mclear_i),
        .mclk_o    (mclk_o),
        .irq_o     (irq_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input word_t got, input word_t exp);
        report_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    always @(posedge wb_clk_i) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            report_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output word_t value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Threshold holds bit 31 over bits 14:0 and reads back sign-extended
    function automatic word_t threshold_word(input word_t w);
        return {{17{w[31]}}, w[14:0]};
    endfunction

    task automatic add_write(input int offset, input word_t wdata, input int settle);
        stim_q.push_back('{is_write: 1'b1, offset: 16'(offset), wdata: wdata, expected: '0,
                           chk_data: 1'b0, chk_irq: 1'b0, exp_irq: 1'b0, settle: 16'(settle),
                           pdm: next_pdm, mclear: next_mclear});
    endtask

    task automatic add_read(input int offset, input word_t expected, input logic chk_irq,
                            input logic exp_irq, input int settle);
        stim_q.push_back('{is_write: 1'b0, offset: 16'(offset), wdata: '0, expected: expected,
                           chk_data: 1'b1, chk_irq: chk_irq, exp_irq: exp_irq,
                           settle: 16'(settle), pdm: next_pdm, mclear: next_mclear});
    endtask

    task automatic build_table();
        word_t value;
        next_pdm    = '0;
        next_mclear = 1'b0;
        add_read(1, 32'd49, 1'b1, 1'b0, 0);             // Reset values
        add_read(0, 32'd0, 1'b1, 1'b0, 0);
        draw_bits(6, value);                            // Small value keeps PCM periods short
        value = value + 32'd1;
        add_write(1, value, 0);
        add_read(1, value, 1'b0, 1'b0, 0);
        for (int k = 0; k < NUM_CH; k++) begin
            draw_bits(32, value);
            add_write(2 + 16 * k, value, 0);
            add_read(2 + 16 * k, threshold_word(value), 1'b0, 1'b0, 0);
            add_read(5 + 16 * k, 32'd0, 1'b0, 1'b0, 0);
        end
        // Channel 0 high, rest low: 8 PDM pulses per 64-cycle PCM period
        next_pdm = 4'b0001;
        add_write(1, 32'd63, 0);
        for (int k = 0; k < NUM_CH; k++) add_write(2 + 16 * k, 32'd0, 0);
        add_read(3, 32'd8, 1'b0, 1'b0, 300);
        for (int k = 1; k < NUM_CH; k++) add_read(3 + 16 * k, 32'hffff_fff8, 1'b0, 1'b0, 0);
        add_read(0, 32'd1, 1'b1, 1'b1, 0);
        next_mclear = 1'b1;
        add_read(0, 32'd0, 1'b1, 1'b0, 300);
        next_mclear = 1'b0;
        add_read(0, 32'd1, 1'b1, 1'b1, 300);
    endtask

    // Request is sampled at the next rising edge, ack is seen two falling edges later
    task automatic run_access(input entry_t e);
        int waited;
        wbs_adr_i = {ADDR_REGION, 28'(e.offset) << 2};
        wbs_dat_i = e.wdata;
        wbs_we_i  = e.is_write;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        @(negedge wb_clk_i);
        waited = 1;
        while (!wbs_ack_o && waited < ACK_WAIT_MAX) begin
            @(negedge wb_clk_i);
            waited++;
        end
        assert (wbs_ack_o)
            else report_failure($sformatf("No acknowledge within %0d cycles", ACK_WAIT_MAX));
        assert (waited == 2)
            else report_failure($sformatf("Acknowledge came %0d cycles after the request", waited));
        if (e.chk_data) begin
            assert (wbs_dat_o === e.expected) else report_value("wbs_dat_o", wbs_dat_o, e.expected);
        end
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        @(negedge wb_clk_i);
        assert (!wbs_ack_o) else report_failure("Acknowledge stayed high for a second cycle");
        if (e.chk_irq) begin
            assert (irq_o === e.exp_irq) else report_value("irq_o", 32'(irq_o), 32'(e.exp_irq));
        end
    endtask

    task automatic check_mclk(input int cycles);
        logic last;
        int   since;
        int   toggles;
        last    = mclk_o;
        since   = 0;
        toggles = 0;
        repeat (cycles) begin
            @(negedge wb_clk_i);
            since++;
            if (mclk_o !== last) begin
                if (toggles > 0) begin
                    assert (since == MCLK_HALF)
                        else report_value("mclk_o toggle interval", since, MCLK_HALF);
                end
                toggles++;
                since = 0;
                last  = mclk_o;
            end
        end
        assert (toggles >= cycles / MCLK_HALF - 1)
            else report_failure("The microphone clock stopped toggling");
    endtask

    initial begin
        int settle_sum;
        wb_rst_i    = 1'b1;
        wbs_cyc_i   = 1'b0;
        wbs_stb_i   = 1'b0;
        wbs_we_i    = 1'b0;
        wbs_adr_i   = '0;
        wbs_dat_i   = '0;
        pdm_i       = '0;
        mclear_i    = 1'b0;
        lfsr_state  = LFSR_SEED;
        build_table();
        settle_sum = 0;
        foreach (stim_q[i]) settle_sum += int'(stim_q[i].settle);
        cycle_limit = stim_q.size() * 8 + settle_sum + 200;
        repeat (3) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;
        foreach (stim_q[i]) begin
            pdm_i    = stim_q[i].pdm;
            mclear_i = stim_q[i].mclear;
            repeat (int'(stim_q[i].settle)) @(negedge wb_clk_i);
            run_access(stim_q[i]);
        end
        check_mclk(MCLK_CHECK_CYCLES);                  // pdm_i is still constant here
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- sources.f
sonar_pkg.sv
sonar_bus_decode.sv
sonar_clock_gen.sv
sonar_channel.sv
sonar_readback.sv
sonar_top.sv
sonar_props.sv
tb_sonar_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the sonar testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sonar_top -f sources.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -qx "Simulation passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; cat sim.log; exit 1; }
